// ==== tb.f ====
verilog/mpmc_chan_pkg.sv
verilog/mpmc_app_pkg.sv
verilog/mpmc_arbiter.sv
verilog/mpmc_cmd_issue.sv
verilog/mpmc_wdf_issue.sv
verilog/mpmc_sequencer.sv
verilog/mpmc_top.sv
verification/mpmc_props.sv
verification/mpmc_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the mpmc testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module mpmc_tb -o vsim_mpmc \
	|| { echo "Build failed"; exit 1; }

./obj_dir/vsim_mpmc > sim.log 2>&1 ; cat sim.log

grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// ==== verification/mpmc_tb.sv ====
`timescale 1ns/1ps

module mpmc_tb
	import mpmc_chan_pkg::*;
	import mpmc_app_pkg::*;
();

localparam int CLK_PERIOD = 40;
localparam int NUM_TESTS = 6;
localparam int ACK_TIMEOUT = 1000;
localparam int WATCHDOG_NS = NUM_TESTS * 2000 * CLK_PERIOD;

logic mem_ui_clk;
logic mem_ui_rst;
logic [NUM_CH-1:0] ch_stb;
logic [NUM_CH-1:0] ch_we;
byte_addr_t [NUM_CH-1:0] ch_adr;
word_t [NUM_CH-1:0] ch_dat_w;
word_sel_t [NUM_CH-1:0] ch_sel;
logic [NUM_CH-1:0] ch_ack;
word_t [NUM_CH-1:0] ch_dat_r;
logic app_rdy;
logic app_en;
app_cmd_t app_cmd;
app_addr_t app_addr;
app_data_t app_wdf_data;
app_mask_t app_wdf_mask;
logic app_wdf_rdy;
logic app_wdf_wren;
logic app_wdf_end;
app_data_t app_rd_data;
logic app_rd_data_valid;

// Memory model state
app_data_t mem [app_addr_t];
app_addr_t pend_wr_addr[$];
app_data_t pend_wd_data[$];
app_mask_t pend_wd_mask[$];
app_cmd_t cmd_log_cmd[$];
app_addr_t cmd_log_addr[$];
app_data_t wdf_log_data[$];
app_mask_t wdf_log_mask[$];
logic stall_en;
logic rd_pending;
int rd_wait;
app_addr_t rd_addr;
int ack_count [NUM_CH];
logic [NUM_CH-1:0] ack_prev;

// Expected word contents, keyed by word address
word_t ref_mem [byte_addr_t];
int last_ch;
int errors;
int checks;
int test_errors;
int tests_run;

mpmc_top i_dut
(
	.mem_ui_clk(mem_ui_clk),
	.mem_ui_rst(mem_ui_rst),
	.ch_stb(ch_stb),
	.ch_we(ch_we),
	.ch_adr(ch_adr),
	.ch_dat_w(ch_dat_w),
	.ch_sel(ch_sel),
	.ch_ack(ch_ack),
	.ch_dat_r(ch_dat_r),
	.app_rdy(app_rdy),
	.app_en(app_en),
	.app_cmd(app_cmd),
	.app_addr(app_addr),
	.app_wdf_data(app_wdf_data),
	.app_wdf_mask(app_wdf_mask),
	.app_wdf_rdy(app_wdf_rdy),
	.app_wdf_wren(app_wdf_wren),
	.app_wdf_end(app_wdf_end),
	.app_rd_data(app_rd_data),
	.app_rd_data_valid(app_rd_data_valid)
);

always #(CLK_PERIOD/2) mem_ui_clk = ~mem_ui_clk;

// ====================
// Memory model
// ====================

// Unwritten memory reads back a pattern built from its full address
function automatic app_data_t fill_word(app_addr_t a);
	app_data_t w;
	for (int l = 0; l < 4; l++)
		w[l*32 +: 32] = {4'(l), a} ^ 32'h5a3c_96e1;
	return w;
endfunction

function automatic app_data_t mem_read(app_addr_t a);
	return mem.exists(a) ? mem[a] : fill_word(a);
endfunction

function automatic void mem_write(app_addr_t a, app_data_t d, app_mask_t m);
	app_data_t w;
	w = mem_read(a);
	for (int j = 0; j < 16; j++)
		if (!m[j])
			w[j*8 +: 8] = d[j*8 +: 8];
	mem[a] = w;
endfunction

// Transfers are sampled mid-cycle, responses driven just after the edge
always
begin
	@(negedge mem_ui_clk);
	if (!mem_ui_rst)
	begin
		if (app_en && app_rdy)
		begin
			cmd_log_cmd.push_back(app_cmd);
			cmd_log_addr.push_back(app_addr);
			if (app_cmd == CMD_WRITE)
				pend_wr_addr.push_back(app_addr);
			else
			begin
				rd_pending = 1'b1;
				rd_wait = 1 + $urandom % 5;
				rd_addr = app_addr;
			end
		end
		if (app_wdf_wren && app_wdf_rdy)
		begin
			wdf_log_data.push_back(app_wdf_data);
			wdf_log_mask.push_back(app_wdf_mask);
			pend_wd_data.push_back(app_wdf_data);
			pend_wd_mask.push_back(app_wdf_mask);
		end
		// A write lands once both its command and its data are in
		while (pend_wr_addr.size() > 0 && pend_wd_data.size() > 0)
			mem_write(pend_wr_addr.pop_front(), pend_wd_data.pop_front(),
				pend_wd_mask.pop_front());
	end
	@(posedge mem_ui_clk);
	#2;
	app_rdy = stall_en ? ($urandom % 3 != 0) : 1'b1;
	app_wdf_rdy = stall_en ? ($urandom % 3 != 0) : 1'b1;
	app_rd_data_valid = 1'b0;
	if (rd_pending)
	begin
		if (rd_wait == 0)
		begin
			app_rd_data_valid = 1'b1;
			app_rd_data = mem_read(rd_addr);
			rd_pending = 1'b0;
		end
		else
			rd_wait--;
	end
end

// Counts rising acks per channel
always @(negedge mem_ui_clk)
begin
	for (int i = 0; i < NUM_CH; i++)
		if (ch_ack[i] && !ack_prev[i])
			ack_count[i]++;
	ack_prev = ch_ack;
end

// ====================
// Reference and checks
// ====================
function automatic app_addr_t aligned(byte_addr_t adr);
	return {adr[APP_ADDR_W-1:4], 4'b0000};
endfunction

function automatic word_t ref_read(byte_addr_t adr);
	app_data_t w;
	if (ref_mem.exists({adr[31:2], 2'b00}))
		return ref_mem[{adr[31:2], 2'b00}];
	w = fill_word(aligned(adr));
	return w[adr[3:2]*32 +: 32];
endfunction

function automatic void ref_write(byte_addr_t adr, word_t dat, word_sel_t sel);
	word_t w;
	w = ref_read(adr);
	for (int b = 0; b < 4; b++)
		if (sel[b])
			w[b*8 +: 8] = dat[b*8 +: 8];
	ref_mem[{adr[31:2], 2'b00}] = w;
endfunction

task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
	checks++;
	if (got !== exp)
	begin
		errors++;
		test_errors++;
		$display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
	end
endtask

task automatic finish_test(input string name);
	tests_run++;
	$display("Test %-16s %s (%0d errors)", name, test_errors == 0 ? "ok" : "failed",
		test_errors);
	test_errors = 0;
endtask

task automatic clear_logs();
	cmd_log_cmd.delete();
	cmd_log_addr.delete();
	wdf_log_data.delete();
	wdf_log_mask.delete();
endtask

// ====================
// Channel driver
// ====================

// Returns one ns after the edge where ch_ack reached the level
task automatic wait_ack(input int ch, input logic level, output int n);
	n = 0;
	do
	begin
		@(posedge mem_ui_clk);
		#1;
		n++;
	end
	while (ch_ack[ch] !== level && n < ACK_TIMEOUT);
	if (ch_ack[ch] !== level)
	begin
		errors++;
		test_errors++;
		$display("Channel %0d ack did not go to %0b within %0d cycles", ch, level, ACK_TIMEOUT);
	end
endtask

// Called and left two ns after a rising edge
task automatic access(input int ch, input logic we, input byte_addr_t adr, input word_t dat,
	input word_sel_t sel, output word_t rdata);
	int n;
	ch_we[ch] = we;
	ch_adr[ch] = adr;
	ch_dat_w[ch] = dat;
	ch_sel[ch] = sel;
	ch_stb[ch] = 1'b1;
	wait_ack(ch, 1'b1, n);
	#1;
	rdata = ch_dat_r[ch];
	ch_stb[ch] = 1'b0;
	wait_ack(ch, 1'b0, n);
	check_val($sformatf("ch_ack[%0d] fall delay", ch), n, 1);
	#1;
	last_ch = ch;
endtask

task automatic do_write(input int ch, input byte_addr_t adr, input word_t dat,
	input word_sel_t sel);
	word_t unused;
	app_mask_t m;
	app_data_t d;
	clear_logs();
	access(ch, 1'b1, adr, dat, sel, unused);
	check_val("write command count", cmd_log_cmd.size(), 1);
	check_val("write data count", wdf_log_data.size(), 1);
	if (cmd_log_cmd.size() > 0)
	begin
		check_val("app_cmd", cmd_log_cmd[0], CMD_WRITE);
		check_val("app_addr", cmd_log_addr[0], aligned(adr));
	end
	if (wdf_log_data.size() > 0)
	begin
		// Only the selected bytes of the addressed lane stay unmasked
		m = '1;
		m[adr[3:2]*4 +: 4] = ~sel;
		// Word sits in its lane, all other lanes carry ones
		d = '1;
		d[adr[3:2]*32 +: 32] = dat;
		check_val("app_wdf_mask", wdf_log_mask[0], m);
		check_val("app_wdf_data", wdf_log_data[0], d);
	end
	ref_write(adr, dat, sel);
endtask

task automatic do_read(input int ch, input byte_addr_t adr);
	word_t got;
	word_t exp;
	clear_logs();
	exp = ref_read(adr);
	access(ch, 1'b0, adr, 32'h0, 4'h0, got);
	check_val("read command count", cmd_log_cmd.size(), 1);
	if (cmd_log_cmd.size() > 0)
	begin
		check_val("app_cmd", cmd_log_cmd[0], CMD_READ);
		check_val("app_addr", cmd_log_addr[0], aligned(adr));
	end
	check_val($sformatf("ch_dat_r[%0d]", ch), got, exp);
endtask

// ====================
// Tests
// ====================
task automatic test_reset_idle();
	repeat (5)
	begin
		@(posedge mem_ui_clk);
		#1;
		check_val("app_en", app_en, 0);
		check_val("app_wdf_wren", app_wdf_wren, 0);
		check_val("ch_ack", ch_ack, 0);
	end
	#1;
	finish_test("reset_idle");
endtask

task automatic test_lane_round_trip();
	byte_addr_t adr;
	for (int lane = 0; lane < 4; lane++)
	begin
		adr = 32'h0000_1000 + lane * 4;
		do_write(1, adr, $urandom, 4'hf);
		do_read(1, adr);
	end
	finish_test("lane_round_trip");
endtask

task automatic test_partial_write();
	do_write(2, 32'h0000_2008, 32'h1122_3344, 4'hf);
	do_write(2, 32'h0000_2008, 32'haabb_ccdd, 4'b0101);
	do_read(2, 32'h0000_2008);
	// Partial write over the fill pattern
	do_write(2, 32'h0000_200c, 32'h7700_0000, 4'b1000);
	do_read(2, 32'h0000_200c);
	finish_test("partial_write");
endtask

task automatic test_random_stalls();
	int ch;
	byte_addr_t adr;
	word_t dat;
	word_sel_t sel;
	stall_en = 1'b1;
	repeat (24)
	begin
		ch = $urandom % NUM_CH;
		adr = 32'h0000_3000 + ($urandom % 16) * 4;
		dat = $urandom;
		sel = 4'($urandom);
		if ($urandom % 2)
			do_write(ch, adr, dat, sel);
		else
			do_read(ch, adr);
	end
	stall_en = 1'b0;
	finish_test("random_stalls");
endtask

task automatic test_all_channels();
	byte_addr_t adrs [NUM_CH];
	word_t got [NUM_CH];
	logic [NUM_CH-1:0] seen;
	int n;
	int first;
	int c;
	for (int i = 0; i < NUM_CH; i++)
	begin
		adrs[i] = 32'h0000_4000 + i * 32'h24;
		do_write(0, adrs[i], 32'hc0de_0000 + i, 4'hf);
	end
	first = (last_ch + 1) % NUM_CH;
	clear_logs();
	for (int i = 0; i < NUM_CH; i++)
	begin
		ack_count[i] = 0;
		ch_we[i] = 1'b0;
		ch_adr[i] = adrs[i];
		ch_sel[i] = 4'h0;
	end
	ch_stb = '1;
	seen = '0;
	n = 0;
	while (seen != '1 && n < ACK_TIMEOUT)
	begin
		@(posedge mem_ui_clk);
		#1;
		n++;
		for (int i = 0; i < NUM_CH; i++)
			if (ch_ack[i] && !seen[i])
			begin
				got[i] = ch_dat_r[i];
				seen[i] = 1'b1;
			end
		#1;
		ch_stb = ch_stb & ~seen;
	end
	if (seen != '1)
	begin
		errors++;
		test_errors++;
		$display("Not every channel was acknowledged within %0d cycles", ACK_TIMEOUT);
	end
	repeat (3) @(posedge mem_ui_clk);
	#1;
	check_val("ch_ack after release", ch_ack, 0);
	#1;
	check_val("command count", cmd_log_addr.size(), NUM_CH);
	for (int k = 0; k < NUM_CH && k < cmd_log_addr.size(); k++)
	begin
		c = (first + k) % NUM_CH;
		check_val($sformatf("app_addr of command %0d", k), cmd_log_addr[k], aligned(adrs[c]));
	end
	for (int i = 0; i < NUM_CH; i++)
	begin
		check_val($sformatf("ack count of channel %0d", i), ack_count[i], 1);
		check_val($sformatf("ch_dat_r[%0d]", i), got[i], ref_read(adrs[i]));
	end
	last_ch = (first + NUM_CH - 1) % NUM_CH;
	finish_test("all_channels");
endtask

task automatic test_held_strobe();
	int n;
	byte_addr_t adr;
	adr = 32'h0000_5004;
	do_write(3, adr, 32'h0bad_f00d, 4'hf);
	clear_logs();
	ch_we[3] = 1'b0;
	ch_adr[3] = adr;
	ch_sel[3] = 4'h0;
	ch_stb[3] = 1'b1;
	wait_ack(3, 1'b1, n);
	check_val("ch_dat_r[3]", ch_dat_r[3], ref_read(adr));
	repeat (10)
	begin
		@(posedge mem_ui_clk);
		#1;
		check_val("ch_ack[3] while held", ch_ack[3], 1);
	end
	check_val("commands while held", cmd_log_cmd.size(), 1);
	#1;
	ch_stb[3] = 1'b0;
	wait_ack(3, 1'b0, n);
	repeat (5) @(posedge mem_ui_clk);
	#2;
	check_val("commands after release", cmd_log_cmd.size(), 1);
	last_ch = 3;
	// A fresh strobe edge is served again
	do_read(3, adr);
	finish_test("held_strobe");
endtask

// ====================
// Run control
// ====================
initial
begin
	#(WATCHDOG_NS);
	$display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
	$display("TESTBENCH FAILED");
	$finish;
end

initial
begin
	void'($urandom(32'hdf46));
	mem_ui_clk = 1'b0;
	mem_ui_rst = 1'b1;
	ch_stb = '0;
	ch_we = '0;
	ch_adr = '0;
	ch_dat_w = '0;
	ch_sel = '0;
	app_rdy = 1'b1;
	app_wdf_rdy = 1'b1;
	app_rd_data = '0;
	app_rd_data_valid = 1'b0;
	stall_en = 1'b0;
	rd_pending = 1'b0;
	rd_wait = 0;
	ack_prev = '0;
	last_ch = 0;
	errors = 0;
	checks = 0;
	test_errors = 0;
	tests_run = 0;
	repeat (10) @(posedge mem_ui_clk);
	#2;
	mem_ui_rst = 1'b0;

	test_reset_idle();
	test_lane_round_trip();
	test_partial_write();
	test_random_stalls();
	test_all_channels();
	test_held_strobe();

	$display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
	if (errors == 0)
		$display("TESTBENCH PASSED");
	else
		$display("TESTBENCH FAILED");
	$finish;
end

endmodule

// ==== verification/mpmc_props.sv ====
`timescale 1ns/1ps

module mpmc_props
	import mpmc_chan_pkg::*;
	import mpmc_app_pkg::*;
(
	input logic              mem_ui_clk,
	input logic              mem_ui_rst,
	input logic              app_en,
	input logic              app_rdy,
	input app_cmd_t          app_cmd,
	input app_addr_t         app_addr,
	input logic              app_wdf_wren,
	input logic              app_wdf_rdy,
	input app_data_t         app_wdf_data,
	input app_mask_t         app_wdf_mask,
	input logic              app_wdf_end,
	input logic [NUM_CH-1:0] ch_ack
);

// ====================
// App port handshakes
// ====================

// A stalled command stays on the port unchanged
a_cmd_hold: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
	app_en && !app_rdy |=> app_en && $stable(app_cmd) && $stable(app_addr))
	else $error("app command changed or dropped before app_rdy");

// Same for stalled write data
a_wdf_hold: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
	app_wdf_wren && !app_wdf_rdy |=> app_wdf_wren && $stable(app_wdf_data)
	&& $stable(app_wdf_mask))
	else $error("app write data changed or dropped before app_wdf_rdy");

a_wdf_end: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
	app_wdf_end == app_wdf_wren)
	else $error("app_wdf_end differs from app_wdf_wren");

// ====================
// Channel side
// ====================
a_one_ack: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
	$onehot0(ch_ack))
	else $error("more than one ch_ack high");

endmodule

bind mpmc_top mpmc_props i_props
(
	.mem_ui_clk(mem_ui_clk),
	.mem_ui_rst(mem_ui_rst),
	.app_en(app_en),
	.app_rdy(app_rdy),
	.app_cmd(app_cmd),
	.app_addr(app_addr),
	.app_wdf_wren(app_wdf_wren),
	.app_wdf_rdy(app_wdf_rdy),
	.app_wdf_data(app_wdf_data),
	.app_wdf_mask(app_wdf_mask),
	.app_wdf_end(app_wdf_end),
	.ch_ack(ch_ack)
);

// ==== verilog/mpmc_top.sv ====
`timescale 1ns/1ps

module mpmc_top
	import mpmc_chan_pkg::*;
	import mpmc_app_pkg::*;
(
	input  logic                    mem_ui_clk,
	input  logic                    mem_ui_rst,
	// Client channels
	input  logic [NUM_CH-1:0]       ch_stb,
	input  logic [NUM_CH-1:0]       ch_we,
	input  byte_addr_t [NUM_CH-1:0] ch_adr,
	input  word_t [NUM_CH-1:0]      ch_dat_w,
	input  word_sel_t [NUM_CH-1:0]  ch_sel,
	output logic [NUM_CH-1:0]       ch_ack,
	output word_t [NUM_CH-1:0]      ch_dat_r,
	// Memory controller app port
	input  logic                    app_rdy,
	output logic                    app_en,
	output app_cmd_t                app_cmd,
	output app_addr_t               app_addr,
	output app_data_t               app_wdf_data,
	output app_mask_t               app_wdf_mask,
	input  logic                    app_wdf_rdy,
	output logic                    app_wdf_wren,
	output logic                    app_wdf_end,
	input  app_data_t               app_rd_data,
	input  logic                    app_rd_data_valid
);

logic req_valid;
chan_idx_t req_ch;
logic req_we;
byte_addr_t req_adr;
word_t req_dat;
word_sel_t req_sel;
logic req_take;
logic ch_done;
chan_idx_t done_ch;

// ====================
// Request side
// ====================
mpmc_arbiter u_arbiter
(
	.mem_ui_clk(mem_ui_clk),
	.mem_ui_rst(mem_ui_rst),
	.ch_stb(ch_stb),
	.ch_we(ch_we),
	.ch_adr(ch_adr),
	.ch_dat_w(ch_dat_w),
	.ch_sel(ch_sel),
	.req_take(req_take),
	.ch_done(ch_done),
	.done_ch(done_ch),
	.req_valid(req_valid),
	.req_ch(req_ch),
	.req_we(req_we),
	.req_adr(req_adr),
	.req_dat(req_dat),
	.req_sel(req_sel)
);

// ====================
// Memory side
// ====================
mpmc_sequencer u_sequencer
(
	.mem_ui_clk(mem_ui_clk),
	.mem_ui_rst(mem_ui_rst),
	.req_valid(req_valid),
	.req_ch(req_ch),
	.req_we(req_we),
	.req_adr(req_adr),
	.req_dat(req_dat),
	.req_sel(req_sel),
	.ch_stb(ch_stb),
	.app_rdy(app_rdy),
	.app_wdf_rdy(app_wdf_rdy),
	.app_rd_data(app_rd_data),
	.app_rd_data_valid(app_rd_data_valid),
	.req_take(req_take),
	.ch_done(ch_done),
	.done_ch(done_ch),
	.ch_ack(ch_ack),
	.ch_dat_r(ch_dat_r),
	.app_en(app_en),
	.app_cmd(app_cmd),
	.app_addr(app_addr),
	.app_wdf_data(app_wdf_data),
	.app_wdf_mask(app_wdf_mask),
	.app_wdf_wren(app_wdf_wren),
	.app_wdf_end(app_wdf_end),
	.state()
);

endmodule

// ==== verilog/mpmc_sequencer.sv ====
`timescale 1ns/1ps

module mpmc_sequencer
	import mpmc_chan_pkg::*;
	import mpmc_app_pkg::*;
(
	input  logic               mem_ui_clk,
	input  logic               mem_ui_rst,
	input  logic               req_valid,
	input  chan_idx_t          req_ch,
	input  logic               req_we,
	input  byte_addr_t         req_adr,
	input  word_t              req_dat,
	input  word_sel_t          req_sel,
	input  logic [NUM_CH-1:0]  ch_stb,
	input  logic               app_rdy,
	input  logic               app_wdf_rdy,
	input  app_data_t          app_rd_data,
	input  logic               app_rd_data_valid,
	output logic               req_take,
	output logic               ch_done,
	output chan_idx_t          done_ch,
	output logic [NUM_CH-1:0]  ch_ack,
	output word_t [NUM_CH-1:0] ch_dat_r,
	output logic               app_en,
	output app_cmd_t           app_cmd,
	output app_addr_t          app_addr,
	output app_data_t          app_wdf_data,
	output app_mask_t          app_wdf_mask,
	output logic               app_wdf_wren,
	output logic               app_wdf_end,
	output seq_state_t         state
);

logic cmd_start;
logic wdf_start;
logic cmd_done;
logic wdf_done;
logic got_cmd;
logic got_wdf;
logic cmd_seen;
logic wdf_seen;
seq_state_t state_nxt;
chan_idx_t cur_ch;
logic cur_we;
logic [LANE_SHIFT-1:0] cur_lane;

// ====================
// Transaction start
// ====================
assign req_take = (state == IDLE) && req_valid;
assign cmd_start = req_take;
assign wdf_start = req_take && req_we;

always_ff @(posedge mem_ui_clk)
if (req_take)
begin
	cur_ch <= req_ch;
	cur_we <= req_we;
	cur_lane <= req_adr[LANE_SHIFT+1:2];
end

// Completions may come in either order, or together
assign cmd_seen = got_cmd || cmd_done;
assign wdf_seen = got_wdf || wdf_done;

always_ff @(posedge mem_ui_clk)
if (mem_ui_rst)
begin
	got_cmd <= 1'b0;
	got_wdf <= 1'b0;
end
else if (req_take)
begin
	got_cmd <= 1'b0;
	got_wdf <= 1'b0;
end
else
begin
	if (cmd_done)
		got_cmd <= 1'b1;
	if (wdf_done)
		got_wdf <= 1'b1;
end

// ====================
// State machine
// ====================
always_comb
begin
	state_nxt = state;
	case (state)
	IDLE:
		if (req_valid)
			state_nxt = ISSUE;
	ISSUE:
		if (cur_we && cmd_seen && wdf_seen)
			state_nxt = ACK;
		else if (!cur_we && cmd_done)
			state_nxt = WAIT_RD;
	WAIT_RD:
		if (app_rd_data_valid)
			state_nxt = ACK;
	ACK:
		// Held until the client lets go of its strobe
		if (!ch_stb[cur_ch])
			state_nxt = IDLE;
	default:
		state_nxt = IDLE;
	endcase
end

always_ff @(posedge mem_ui_clk)
if (mem_ui_rst)
	state <= IDLE;
else
	state <= state_nxt;

// Read word pulled out of its lane
always_ff @(posedge mem_ui_clk)
if (state == WAIT_RD && app_rd_data_valid)
	ch_dat_r[cur_ch] <= app_rd_data[cur_lane*$bits(word_t) +: $bits(word_t)];

always_comb
begin
	for (int i = 0; i < NUM_CH; i++)
		ch_ack[i] = (state == ACK) && (cur_ch == chan_idx_t'(i));
end

// Lets the arbiter rearm this channel
assign ch_done = (state == ACK) && !ch_stb[cur_ch];
assign done_ch = cur_ch;

// ====================
// Issue blocks
// ====================
mpmc_cmd_issue u_cmd_issue
(
	.mem_ui_clk(mem_ui_clk),
	.mem_ui_rst(mem_ui_rst),
	.cmd_start(cmd_start),
	.start_we(req_we),
	.start_adr(req_adr),
	.app_rdy(app_rdy),
	.app_en(app_en),
	.app_cmd(app_cmd),
	.app_addr(app_addr),
	.cmd_done(cmd_done)
);

mpmc_wdf_issue u_wdf_issue
(
	.mem_ui_clk(mem_ui_clk),
	.mem_ui_rst(mem_ui_rst),
	.wdf_start(wdf_start),
	.start_adr(req_adr),
	.start_dat(req_dat),
	.start_sel(req_sel),
	.app_wdf_rdy(app_wdf_rdy),
	.app_wdf_data(app_wdf_data),
	.app_wdf_mask(app_wdf_mask),
	.app_wdf_wren(app_wdf_wren),
	.app_wdf_end(app_wdf_end),
	.wdf_done(wdf_done)
);

endmodule

// ==== verilog/mpmc_wdf_issue.sv ====
`timescale 1ns/1ps

module mpmc_wdf_issue
	import mpmc_chan_pkg::*;
	import mpmc_app_pkg::*;
(
	input  logic       mem_ui_clk,
	input  logic       mem_ui_rst,
	input  logic       wdf_start,
	input  byte_addr_t start_adr,
	input  word_t      start_dat,
	input  word_sel_t  start_sel,
	input  logic       app_wdf_rdy,
	output app_data_t  app_wdf_data,
	output app_mask_t  app_wdf_mask,
	output logic       app_wdf_wren,
	output logic       app_wdf_end,
	output logic       wdf_done
);

logic [LANE_SHIFT-1:0] lane;

assign lane = start_adr[LANE_SHIFT+1:2];

// Single strip per write so end tracks wren
assign app_wdf_end = app_wdf_wren;
assign wdf_done = app_wdf_wren && app_wdf_rdy;

always_ff @(posedge mem_ui_clk)
if (mem_ui_rst)
	app_wdf_wren <= 1'b0;
else
begin
	if (wdf_start)
		app_wdf_wren <= 1'b1;
	else if (wdf_done)
		app_wdf_wren <= 1'b0;
end

// ====================
// Lane placement
// ====================

// Mask bit set means byte not written, so only the selected
// bytes of the addressed lane are left clear
always_ff @(posedge mem_ui_clk)
if (wdf_start)
begin
	for (int l = 0; l < APP_DATA_W/$bits(word_t); l++)
	begin
		if (lane == l)
		begin
			app_wdf_data[l*$bits(word_t) +: $bits(word_t)] <= start_dat;
			app_wdf_mask[l*$bits(word_sel_t) +: $bits(word_sel_t)] <= ~start_sel;
		end
		else
		begin
			// Unused lanes forced to ones
			app_wdf_data[l*$bits(word_t) +: $bits(word_t)] <= '1;
			app_wdf_mask[l*$bits(word_sel_t) +: $bits(word_sel_t)] <= '1;
		end
	end
end

endmodule

// ==== verilog/mpmc_cmd_issue.sv ====
`timescale 1ns/1ps

module mpmc_cmd_issue
	import mpmc_chan_pkg::*;
	import mpmc_app_pkg::*;
(
	input  logic       mem_ui_clk,
	input  logic       mem_ui_rst,
	input  logic       cmd_start,
	input  logic       start_we,
	input  byte_addr_t start_adr,
	input  logic       app_rdy,
	output logic       app_en,
	output app_cmd_t   app_cmd,
	output app_addr_t  app_addr,
	output logic       cmd_done
);

// Command is accepted on any cycle with app_en and app_rdy both high
assign cmd_done = app_en && app_rdy;

always_ff @(posedge mem_ui_clk)
if (mem_ui_rst)
	app_en <= 1'b0;
else
begin
	if (cmd_start)
		app_en <= 1'b1;
	else if (cmd_done)
		app_en <= 1'b0;
end

// Command and address are held until accepted
always_ff @(posedge mem_ui_clk)
if (cmd_start)
begin
	app_cmd <= start_we ? CMD_WRITE : CMD_READ;
	// Aligned to a whole app word, lane and byte bits cleared
	app_addr <= {start_adr[APP_ADDR_W-1:LANE_SHIFT+2], {(LANE_SHIFT+2){1'b0}}};
end

endmodule

// ==== verilog/mpmc_arbiter.sv ====
`timescale 1ns/1ps

module mpmc_arbiter
	import mpmc_chan_pkg::*;
(
	input  logic                    mem_ui_clk,
	input  logic                    mem_ui_rst,
	input  logic [NUM_CH-1:0]       ch_stb,
	input  logic [NUM_CH-1:0]       ch_we,
	input  byte_addr_t [NUM_CH-1:0] ch_adr,
	input  word_t [NUM_CH-1:0]      ch_dat_w,
	input  word_sel_t [NUM_CH-1:0]  ch_sel,
	input  logic                    req_take,
	input  logic                    ch_done,
	input  chan_idx_t               done_ch,
	output logic                    req_valid,
	output chan_idx_t               req_ch,
	output logic                    req_we,
	output byte_addr_t              req_adr,
	output word_t                   req_dat,
	output word_sel_t               req_sel
);

logic [NUM_CH-1:0] stb_q;
logic [NUM_CH-1:0] armed;
logic [NUM_CH-1:0] stb_rise;
logic [NUM_CH-1:0] pending;
chan_idx_t last_ch;
chan_idx_t pick;
logic found;
logic grant;

// ====================
// Strobe edge detect
// ====================

// A channel is disarmed once its edge is taken and rearmed when its transaction ends
assign stb_rise = ch_stb & ~stb_q & armed;

always_ff @(posedge mem_ui_clk)
if (mem_ui_rst)
begin
	stb_q <= '0;
	armed <= '1;
	pending <= '0;
end
else
begin
	stb_q <= ch_stb;
	for (int i = 0; i < NUM_CH; i++)
	begin
		if (stb_rise[i])
			armed[i] <= 1'b0;
		else if (ch_done && done_ch == chan_idx_t'(i))
			armed[i] <= 1'b1;
		if (stb_rise[i])
			pending[i] <= 1'b1;
		else if (grant && pick == chan_idx_t'(i))
			pending[i] <= 1'b0;
	end
end

// ====================
// Round-robin pick
// ====================

// Search starts one past the last winner and wraps
always_comb
begin
	chan_idx_t idx;
	found = 1'b0;
	pick = last_ch;
	for (int k = 1; k <= NUM_CH; k++)
	begin
		idx = last_ch + chan_idx_t'(k);
		if (!found && pending[idx])
		begin
			found = 1'b1;
			pick = idx;
		end
	end
end

// Only one request is held at a time
assign grant = !req_valid && found;

always_ff @(posedge mem_ui_clk)
if (mem_ui_rst)
begin
	req_valid <= 1'b0;
	last_ch <= '0;
end
else if (grant)
begin
	req_valid <= 1'b1;
	last_ch <= pick;
end
else if (req_take)
	req_valid <= 1'b0;

// Winner fields, stable while req_valid is high
always_ff @(posedge mem_ui_clk)
if (grant)
begin
	req_we <= ch_we[pick];
	req_adr <= ch_adr[pick];
	req_dat <= ch_dat_w[pick];
	req_sel <= ch_sel[pick];
end

assign req_ch = last_ch;

endmodule

// ==== verilog/mpmc_app_pkg.sv ====
package mpmc_app_pkg;

// ====================
// App port geometry
// ====================

localparam int APP_DATA_W = 128;
localparam int APP_ADDR_W = 28;

// Address bits 3:2 pick a 32-bit lane inside one app word
localparam int LANE_SHIFT = 2;

typedef logic [APP_DATA_W-1:0] app_data_t;
typedef logic [APP_DATA_W/8-1:0] app_mask_t;
typedef logic [APP_ADDR_W-1:0] app_addr_t;
typedef logic [2:0] app_cmd_t;

// Command codes seen by the memory controller
localparam app_cmd_t CMD_WRITE = 3'd0;
localparam app_cmd_t CMD_READ = 3'd1;

// ====================
// Sequencer states
// ====================
typedef enum logic [1:0] {
	IDLE,
	ISSUE,
	WAIT_RD,
	ACK
} seq_state_t;

endpackage

// ==== verilog/mpmc_chan_pkg.sv ====
package mpmc_chan_pkg;

// ====================
// Channel geometry
// ====================

// Number of client channels sharing the controller
localparam int NUM_CH = 4;

// Bits needed to name one channel
localparam int CH_IDX_W = 2;

// ====================
// Channel field types
// ====================

// Channel number as carried between arbiter and sequencer
typedef logic [CH_IDX_W-1:0] chan_idx_t;

// Byte address as issued by a client
typedef logic [31:0] byte_addr_t;

// One client data word
typedef logic [31:0] word_t;

// Byte selects, one per byte of word_t
typedef logic [3:0] word_sel_t;

endpackage
